/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam logic [ADDR_W-1:0] RESET_PC = 32'h8000_0000;

  // direct mapped, one word per line
  localparam int ICACHE_SETS = 16;
  localparam int IDX_W       = 4;            // pc[5:2]
  localparam int TAG_W       = ADDR_W - IDX_W - 2; // pc[31:6]

  // rv32i base opcodes
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_FENCE  = 7'b0001111;
  localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

  typedef enum logic [3:0] {
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
    OP_STORE, OP_ALU_IMM, OP_ALU, OP_FENCE, OP_SYSTEM, OP_ILLEGAL
  } op_class_e;

  typedef enum logic [1:0] {
    IC_IDLE, IC_MISS, IC_RESP
  } icache_state_e;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] inst;
  } fetch_rsp_t;

  typedef struct packed {
    logic [ADDR_W-1:0] pc;
    logic [DATA_W-1:0] inst;
    op_class_e         op;
  } dec_out_t;

  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] target;
  } redirect_t;

endpackage

`default_nettype wire

/* src/pc_seq.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_seq
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output logic       req_valid_o,
  output fetch_req_t req_o,
  input  logic       req_ready_i,
  input  redirect_t  redirect_i
);

  logic [ADDR_W-1:0] pc_q;
  logic              valid_q;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc_q    <= RESET_PC;
      valid_q <= 1'b0;
    end
    else
    begin
      valid_q <= 1'b1; // requests run free after reset
      // redirect wins over a same cycle advance
      if (redirect_i.valid)
        pc_q <= redirect_i.target;
      else if (req_valid_o && req_ready_i)
        pc_q <= pc_q + ADDR_W'(4);
    end
  end

  assign req_valid_o = valid_q;
  assign req_o.pc    = pc_q;

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_redirect_aligned : assert property (@(posedge clk) disable iff (rst)
    redirect_i.valid |-> (redirect_i.target[1:0] == 2'b00));

endmodule

`default_nettype wire

/* src/icache_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module icache_fetch
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              req_valid_i,
  input  fetch_req_t        req_i,
  output logic              req_ready_o,
  output logic              rsp_valid_o,
  output fetch_rsp_t        rsp_o,
  input  logic              rsp_ready_i,
  output logic [ADDR_W-1:0] mem_araddr_o,
  output logic              mem_arvalid_o,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  logic              mem_rvalid_i
);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  logic [DATA_W-1:0]      data_arr [ICACHE_SETS];
  logic [TAG_W-1:0]       tag_arr  [ICACHE_SETS];
  logic [ICACHE_SETS-1:0] line_valid_q;

  icache_state_e     state_q;
  logic [ADDR_W-1:0] pc_q;   // pc of the request in flight

  logic [IDX_W-1:0] req_idx;
  logic [TAG_W-1:0] req_tag;
  logic [IDX_W-1:0] cur_idx;
  logic [TAG_W-1:0] cur_tag;
  logic             req_hit;
  logic             accept;
  logic             fill;

  assign req_idx = req_i.pc[IDX_W+1:2];
  assign req_tag = req_i.pc[ADDR_W-1:IDX_W+2];
  assign cur_idx = pc_q[IDX_W+1:2];
  assign cur_tag = pc_q[ADDR_W-1:IDX_W+2];

  // lookup against the incoming pc
  assign req_hit = line_valid_q[req_idx] && (tag_arr[req_idx] == req_tag);
  assign accept  = req_valid_i && req_ready_o;
  assign fill    = (state_q == IC_MISS) && mem_rvalid_i;

  //////////////////////////////////////////////////////////////////////
  // miss FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state_q      <= IC_IDLE;
      line_valid_q <= '0;
    end
    else
    begin
      case (state_q)
        IC_IDLE:
          if (accept)
            state_q <= req_hit ? IC_RESP : IC_MISS;
        IC_MISS:
          if (mem_rvalid_i)
          begin
            state_q               <= IC_RESP;
            line_valid_q[cur_idx] <= 1'b1;
          end
        IC_RESP:
          if (rsp_ready_i)
            state_q <= IC_IDLE;
        default: state_q <= IC_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (accept)
      pc_q <= req_i.pc;
    if (fill)
    begin
      data_arr[cur_idx] <= mem_rdata_i;
      tag_arr[cur_idx]  <= cur_tag;
    end
  end

  assign req_ready_o   = (state_q == IC_IDLE);
  assign mem_arvalid_o = (state_q == IC_MISS);
  assign mem_araddr_o  = pc_q;

  // hit and filled line both read back from the array
  assign rsp_valid_o = (state_q == IC_RESP);
  assign rsp_o.pc    = pc_q;
  assign rsp_o.inst  = data_arr[cur_idx];

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  a_rvalid_in_miss : assert property (@(posedge clk) disable iff (rst)
    mem_rvalid_i |-> (state_q == IC_MISS));

  a_araddr_stable : assert property (@(posedge clk) disable iff (rst)
    (mem_arvalid_o && !mem_rvalid_i) |=> (mem_arvalid_o && $stable(mem_araddr_o)));

  a_rsp_stable : assert property (@(posedge clk) disable iff (rst)
    (rsp_valid_o && !rsp_ready_i) |=> (rsp_valid_o && $stable(rsp_o)));

endmodule

`default_nettype wire

/* src/inst_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decode
  import fetch_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       rsp_valid_i,
  input  fetch_rsp_t rsp_i,
  output logic       rsp_ready_o,
  output logic       out_valid_o,
  output dec_out_t   out_o,
  input  logic       out_ready_i,
  output redirect_t  redirect_o
);

  logic              full_q;
  dec_out_t          out_q;
  logic [ADDR_W-1:0] exp_pc_q;
  logic              redir_valid_q;
  logic [ADDR_W-1:0] redir_target_q;

  op_class_e         op;
  logic [ADDR_W-1:0] j_imm;
  logic [ADDR_W-1:0] next_pc;
  logic              accept;
  logic              take;   // accepted and on the expected path

  // full 7 bit match, so low bits other than 11 fall to illegal
  always_comb
  begin
    case (rsp_i.inst[6:0])
      OPC_LUI:    op = OP_LUI;
      OPC_AUIPC:  op = OP_AUIPC;
      OPC_JAL:    op = OP_JAL;
      OPC_JALR:   op = OP_JALR;
      OPC_BRANCH: op = OP_BRANCH;
      OPC_LOAD:   op = OP_LOAD;
      OPC_STORE:  op = OP_STORE;
      OPC_OP_IMM: op = OP_ALU_IMM;
      OPC_OP:     op = OP_ALU;
      OPC_FENCE:  op = OP_FENCE;
      OPC_SYSTEM: op = OP_SYSTEM;
      default:    op = OP_ILLEGAL;
    endcase
  end

  assign j_imm   = {{12{rsp_i.inst[31]}}, rsp_i.inst[19:12], rsp_i.inst[20],
                    rsp_i.inst[30:21], 1'b0};
  assign next_pc = (op == OP_JAL) ? rsp_i.pc + j_imm : rsp_i.pc + ADDR_W'(4);

  assign rsp_ready_o = !full_q || out_ready_i;
  assign accept      = rsp_valid_i && rsp_ready_o;
  assign take        = accept && (rsp_i.pc == exp_pc_q);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      full_q        <= 1'b0;
      exp_pc_q      <= RESET_PC;
      redir_valid_q <= 1'b0;
    end
    else
    begin
      if (take)
        full_q <= 1'b1;
      else if (out_ready_i)
        full_q <= 1'b0;
      if (take)
        exp_pc_q <= next_pc;
      redir_valid_q <= take && (op == OP_JAL);
    end
  end

  always_ff @(posedge clk)
  begin
    if (take)
    begin
      out_q          <= '{pc: rsp_i.pc, inst: rsp_i.inst, op: op};
      redir_target_q <= next_pc;
    end
  end

  assign out_valid_o = full_q;
  assign out_o       = out_q;
  assign redirect_o  = '{valid: redir_valid_q, target: redir_target_q};

  a_redirect_pulse : assert property (@(posedge clk) disable iff (rst)
    redirect_o.valid |=> !redirect_o.valid);

endmodule

`default_nettype wire

/* src/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top
  import fetch_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  output logic [ADDR_W-1:0] mem_araddr_o,
  output logic              mem_arvalid_o,
  input  logic [DATA_W-1:0] mem_rdata_i,
  input  logic              mem_rvalid_i,
  output logic              out_valid_o,
  output dec_out_t          out_o,
  input  logic              out_ready_i
);

  logic       req_valid;
  logic       req_ready;
  fetch_req_t req;
  logic       rsp_valid;
  logic       rsp_ready;
  fetch_rsp_t rsp;
  redirect_t  redirect;

  //////////////////////////////////////////////////////////////////////
  // producer -> cache -> decode
  //////////////////////////////////////////////////////////////////////

  pc_seq i_pc_seq (
    .clk         (clk),
    .rst         (rst),
    .req_valid_o (req_valid),
    .req_o       (req),
    .req_ready_i (req_ready),
    .redirect_i  (redirect)
  );

  icache_fetch i_icache_fetch (
    .clk           (clk),
    .rst           (rst),
    .req_valid_i   (req_valid),
    .req_i         (req),
    .req_ready_o   (req_ready),
    .rsp_valid_o   (rsp_valid),
    .rsp_o         (rsp),
    .rsp_ready_i   (rsp_ready),
    .mem_araddr_o  (mem_araddr_o),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i)
  );

  inst_decode i_inst_decode (
    .clk         (clk),
    .rst         (rst),
    .rsp_valid_i (rsp_valid),
    .rsp_i       (rsp),
    .rsp_ready_o (rsp_ready),
    .out_valid_o (out_valid_o),
    .out_o       (out_o),
    .out_ready_i (out_ready_i),
    .redirect_o  (redirect)     // back to the sequencer
  );

endmodule

`default_nettype wire

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_o
);

  initial
  begin
    clk_o = 1'b0;
    rst_o = 1'b1;
    repeat (2) @(negedge clk_o); // two rising edges in reset
    rst_o = 1'b0;
  end

  always #5 clk_o = ~clk_o; // 10 ns period

endmodule

`default_nettype wire

/* verif/fetch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
  import fetch_pkg::*;
();

  localparam int MEM_WORDS = 64;
  localparam int TOTAL_OUT = 88;   // 12 + 24 + 8 + 8 + 24 + 12

  logic        clk;
  logic        gen_rst;
  logic        tb_rst;
  logic        rst;
  logic [31:0] mem_araddr;
  logic        mem_arvalid;
  logic [31:0] mem_rdata;
  logic        mem_rvalid;
  logic        out_valid;
  dec_out_t    dec_out;
  logic        out_ready;

  logic [31:0] mem_arr  [MEM_WORDS];
  int          rd_count [MEM_WORDS];
  int          lat_fixed;
  bit          lat_random;
  int          err_count;

  assign rst = gen_rst | tb_rst;

  tb_clk_gen i_clk_gen (
    .clk_o (clk),
    .rst_o (gen_rst)
  );

  fetch_top i_fetch_top (
    .clk           (clk),
    .rst           (rst),
    .mem_araddr_o  (mem_araddr),
    .mem_arvalid_o (mem_arvalid),
    .mem_rdata_i   (mem_rdata),
    .mem_rvalid_i  (mem_rvalid),
    .out_valid_o   (out_valid),
    .out_o         (dec_out),
    .out_ready_i   (out_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return addr ^ 32'h5a5a_5a5a; // low two bits come out 10 so it decodes illegal
  endfunction

  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - RESET_PC;
    if (off < 32'(4 * MEM_WORDS))
      return mem_arr[off[31:2]];
    return fill_word(addr);
  endfunction

  function automatic op_class_e class_of(input logic [31:0] inst);
    case (inst[6:0])
      7'h37:   return OP_LUI;
      7'h17:   return OP_AUIPC;
      7'h6f:   return OP_JAL;
      7'h67:   return OP_JALR;
      7'h63:   return OP_BRANCH;
      7'h03:   return OP_LOAD;
      7'h23:   return OP_STORE;
      7'h13:   return OP_ALU_IMM;
      7'h33:   return OP_ALU;
      7'h0f:   return OP_FENCE;
      7'h73:   return OP_SYSTEM;
      default: return OP_ILLEGAL;
    endcase
  endfunction

  // pc+4, or pc plus the J immediate for jal
  function automatic logic [31:0] next_pc(input logic [31:0] pc, input logic [31:0] inst);
    logic [31:0] imm;
    imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    if (inst[6:0] == 7'h6f)
      return pc + imm;
    return pc + 32'd4;
  endfunction

  function automatic logic [31:0] enc_jal(input int off);
    logic [20:0] imm;
    imm = 21'(off);
    return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd0, 7'h6f}; // rd = x0
  endfunction

  //////////////////////////////////////////////////////////////////////
  // memory model and watchdog
  //////////////////////////////////////////////////////////////////////

  initial
  begin : mem_model
    logic [31:0] off;
    int          lat;
    forever
    begin
      @(negedge clk);
      mem_rvalid = 1'b0;
      if (mem_arvalid && !rst)
      begin
        lat = lat_random ? int'($urandom % 6) : lat_fixed;
        repeat (lat) @(negedge clk);
        if (mem_arvalid && !rst) // request may have been killed by reset
        begin
          mem_rdata  = mem_word(mem_araddr);
          mem_rvalid = 1'b1;
          off        = mem_araddr - RESET_PC;
          if (off < 32'(4 * MEM_WORDS))
            rd_count[off[31:2]]++;
        end
      end
    end
  end

  initial
  begin : watchdog
    repeat (TOTAL_OUT * 40) @(posedge clk);
    $display("timeout: the output stream stopped before all tests were done");
    $display("RESULT: FAIL");
    $fatal(1);
  end

  task automatic value_mismatch(input string test, input string what, input logic [31:0] exp,
                                input logic [31:0] act);
    err_count++;
    $display("Fail %s: %s expected %h actual %h", test, what, exp, act);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic stop_on_error(input string test, input string msg);
    err_count++;
    $display("%s: %s", test, msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // test helpers
  //////////////////////////////////////////////////////////////////////

  // raises rst and clears memory and read counts
  task automatic hold_reset(input int lat, input bit rnd);
    @(negedge clk);
    tb_rst    = 1'b1;
    out_ready = 1'b1;
    @(negedge clk);
    lat_fixed  = lat;
    lat_random = rnd;
    for (int i = 0; i < MEM_WORDS; i++)
    begin
      mem_arr[i]  = fill_word(RESET_PC + 32'(4 * i));
      rd_count[i] = 0;
    end
  endtask

  task automatic release_reset();
    @(negedge clk);
    tb_rst = 1'b0;
  endtask

  task automatic mixed_program();
    mem_arr[0]  = 32'h1234_50b7; // lui
    mem_arr[1]  = 32'h0000_0117; // auipc
    mem_arr[2]  = 32'h0010_0193; // addi
    mem_arr[3]  = 32'h0031_8233; // add
    mem_arr[4]  = 32'h0000_2283; // lw
    mem_arr[5]  = 32'h0050_2223; // sw
    mem_arr[6]  = 32'h0010_0463; // beq
    mem_arr[7]  = 32'h0000_8067; // jalr
    mem_arr[8]  = 32'h0ff0_000f; // fence
    mem_arr[9]  = 32'h0000_0073; // ecall
    mem_arr[10] = 32'hffff_ffff;
    mem_arr[11] = 32'h0000_0012; // addi with low bits 10
  endtask

  task automatic loop_program();
    mem_arr[0] = 32'h0010_0193;
    mem_arr[1] = 32'h0031_8233;
    mem_arr[2] = 32'h1234_50b7;
    mem_arr[3] = 32'h0000_2283;
    mem_arr[4] = 32'h0050_2223;
    mem_arr[5] = 32'h0010_0463; // branch that is not followed
    mem_arr[6] = 32'h0000_0117;
    mem_arr[7] = enc_jal(-28);  // back to the start
  endtask

  task automatic check_reads(input string test, input int first, input int last, input int exp);
    for (int i = first; i <= last; i++)
      assert (rd_count[i] == exp)
        else value_mismatch(test, $sformatf("bus reads of %h", RESET_PC + 32'(4 * i)),
                            32'(exp), 32'(rd_count[i]));
  endtask

  // walk the program and check every output handshake
  task automatic run_stream(input string name, input int n_out, input bit stall);
    logic [31:0] exp_pc;
    logic [31:0] exp_inst;
    dec_out_t    held;
    bit          waiting;
    int          got;
    exp_pc  = RESET_PC;
    waiting = 1'b0;
    got     = 0;
    while (got < n_out)
    begin
      @(negedge clk);
      if (waiting)
      begin
        assert (out_valid) else stop_on_error(name, "output valid dropped while stalled");
        assert (dec_out.pc == held.pc)
          else value_mismatch(name, "stalled output pc", held.pc, dec_out.pc);
        assert (dec_out.inst == held.inst)
          else value_mismatch(name, "stalled output inst", held.inst, dec_out.inst);
        assert (dec_out.op == held.op)
          else value_mismatch(name, "stalled output op", 32'(held.op), 32'(dec_out.op));
      end
      out_ready = stall ? (($urandom % 3) != 0) : 1'b1;
      waiting   = out_valid && !out_ready;
      held      = dec_out;
      if (out_valid && out_ready)
      begin
        exp_inst = mem_word(exp_pc);
        assert (dec_out.pc == exp_pc) else value_mismatch(name, "pc", exp_pc, dec_out.pc);
        assert (dec_out.inst == exp_inst)
          else value_mismatch(name, "inst", exp_inst, dec_out.inst);
        assert (dec_out.op == class_of(exp_inst))
          else value_mismatch(name, "op", 32'(class_of(exp_inst)), 32'(dec_out.op));
        exp_pc = next_pc(exp_pc, exp_inst);
        got++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // tests
  //////////////////////////////////////////////////////////////////////

  task automatic cold_sequence();
    hold_reset(2, 1'b0);
    mixed_program();
    release_reset();
    run_stream("cold_seq", 12, 1'b0);
    check_reads("cold_seq", 0, 11, 1);
  endtask

  task automatic loop_hits();
    hold_reset(1, 1'b0);
    loop_program();
    release_reset();
    run_stream("loop_hits", 24, 1'b0); // three passes
    check_reads("loop_hits", 0, 7, 1);
  endtask

  task automatic jal_squash();
    hold_reset(0, 1'b0);
    mem_arr[0] = 32'h0010_0193;
    mem_arr[1] = enc_jal(16);   // skips words 2..4
    mem_arr[2] = 32'h1234_50b7;
    mem_arr[3] = 32'h0000_0117;
    mem_arr[4] = 32'h0000_2283;
    mem_arr[5] = 32'h0031_8233;
    mem_arr[6] = 32'h0050_2223;
    mem_arr[7] = enc_jal(-28);
    release_reset();
    run_stream("jal_squash", 8, 1'b0);
    check_reads("jal_squash", 3, 4, 0); // only pc+4 may be fetched
  endtask

  task automatic conflict_eviction();
    hold_reset(3, 1'b0);
    mem_arr[0]  = enc_jal(64);  // same index with another tag
    mem_arr[16] = enc_jal(-64);
    release_reset();
    run_stream("conflict", 8, 1'b0);
    check_reads("conflict", 0, 0, 4);
    check_reads("conflict", 16, 16, 4);
  endtask

  task automatic back_pressure();
    hold_reset(1, 1'b0);
    loop_program();
    release_reset();
    run_stream("backpressure", 24, 1'b1);
    check_reads("backpressure", 0, 7, 1);
  endtask

  task automatic random_latency();
    hold_reset(0, 1'b1);
    mixed_program();
    release_reset();
    run_stream("random_lat", 12, 1'b0);
    check_reads("random_lat", 0, 11, 1);
  endtask

  initial
  begin
    tb_rst     = 1'b1;
    out_ready  = 1'b1;
    mem_rdata  = '0;
    mem_rvalid = 1'b0;
    lat_fixed  = 0;
    lat_random = 1'b0;
    err_count  = 0;
    void'($urandom(47794));
    cold_sequence();
    loop_hits();
    jal_squash();
    conflict_eviction();
    back_pressure();
    random_latency();
    if (err_count == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
src/fetch_pkg.sv
src/pc_seq.sv
src/icache_fetch.sv
src/inst_decode.sv
src/fetch_top.sv
verif/tb_clk_gen.sv
verif/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - files:
      - src/fetch_pkg.sv
      - src/pc_seq.sv
      - src/icache_fetch.sv
      - src/inst_decode.sv
      - src/fetch_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/fetch_tb.sv
